//--- include/mitm_params.svh
// mitm parameters shared by the uart man-in-the-middle design
`ifndef MITM_PARAMS_SVH
`define MITM_PARAMS_SVH

// bits per uart frame
`define MITM_DATA_BITS 8

// mode code and mode led width
`define MITM_MODE_WIDTH 2

// sys_clk cycles per uart bit, simulation value
`define MITM_CLKS_PER_BIT 16

// button must stay stable this long
`define MITM_DEBOUNCE_CYCLES 64

// activity led stretch after last activity
`define MITM_LED_HOLD_CYCLES 256

// substitute mode compare and replacement bytes
`define MITM_MATCH_BYTE 8'h41
`define MITM_SUBST_BYTE 8'h5a

`endif

//--- verilog/mitm_pkg.sv
// mitm package with the mode and uart state machine types
`default_nettype none

`include "mitm_params.svh"

package mitm_pkg;

	// manipulation modes, stepped by the mode button
	typedef enum logic [`MITM_MODE_WIDTH-1:0] {
		MODE_FORWARD = 0,
		MODE_BLOCK   = 1,
		MODE_INVERT  = 2,
		MODE_SUBST   = 3
	} mitm_mode_e;

	typedef enum logic [1:0] {
		RX_IDLE, RX_START, RX_DATA, RX_STOP
	} uart_rx_state_e;

	typedef enum logic [1:0] {
		TX_IDLE, TX_START, TX_DATA, TX_STOP
	} uart_tx_state_e;

endpackage

`default_nettype wire

//--- verilog/line_sync.sv
// line synchronizer, two flop stages per asynchronous input bit
`default_nettype none
`timescale 1ns/1ps

module line_sync #(
	parameter int WIDTH = 1
) (
	input wire sys_clk,
	input wire [WIDTH-1:0] in_line,
	output logic [WIDTH-1:0] out_line
);

	logic [WIDTH-1:0] meta;	// first stage, may go metastable

	always_ff @(posedge sys_clk) begin
		meta <= in_line;
		out_line <= meta;
	end

endmodule

`default_nettype wire

//--- verilog/io_handler.sv
// user i/o handler, button debounce, mode stepping and led driving
`default_nettype none
`timescale 1ns/1ps

`include "mitm_params.svh"

module io_handler (
	input wire sys_clk,
	input wire rst_n,
	input wire mode_btn,
	input wire comm_active,
	output mitm_pkg::mitm_mode_e mode,
	output logic [`MITM_MODE_WIDTH-1:0] mode_leds,
	output logic comm_active_led
);

	localparam int DB_W = $clog2(`MITM_DEBOUNCE_CYCLES);
	localparam int HOLD_W = $clog2(`MITM_LED_HOLD_CYCLES);
	localparam logic [DB_W-1:0] DB_LAST = DB_W'(`MITM_DEBOUNCE_CYCLES - 1);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`MITM_LED_HOLD_CYCLES - 1);

	logic [DB_W-1:0] db_cnt;
	logic btn_level;	// debounced button level
	logic [HOLD_W-1:0] hold_cnt;

	// debounce: a changed level must persist for the whole window
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			db_cnt <= '0;
			btn_level <= 1'b0;
			mode <= mitm_pkg::MODE_FORWARD;
		end else if (mode_btn != btn_level) begin
			if (db_cnt == DB_LAST) begin
				db_cnt <= '0;
				btn_level <= mode_btn;
				if (mode_btn)	// accepted press
					mode <= mitm_pkg::mitm_mode_e'(mode + 1'b1);	// wraps after subst
			end else begin
				db_cnt <= db_cnt + 1'b1;
			end
		end else begin
			db_cnt <= '0;	// bounce, restart window
		end
	end

	assign mode_leds = mode;

	// activity led stays lit for the hold time after last activity
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			hold_cnt <= '0;
			comm_active_led <= 1'b0;
		end else if (comm_active) begin
			hold_cnt <= HOLD_LAST;
			comm_active_led <= 1'b1;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end else begin
			comm_active_led <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
// uart receiver, mid-bit sampling with a one cycle byte valid strobe
`default_nettype none
`timescale 1ns/1ps

`include "mitm_params.svh"

module uart_rx (
	input wire sys_clk,
	input wire rst_n,
	input wire rx,
	output logic valid,
	output logic [`MITM_DATA_BITS-1:0] data
);

	localparam int CNT_W = $clog2(`MITM_CLKS_PER_BIT);
	localparam int IDX_W = $clog2(`MITM_DATA_BITS);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`MITM_CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`MITM_CLKS_PER_BIT - 1);
	localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`MITM_DATA_BITS - 1);

	mitm_pkg::uart_rx_state_e state;
	logic [CNT_W-1:0] clk_cnt;
	logic [IDX_W-1:0] bit_idx;
	logic rx_prev;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state <= mitm_pkg::RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_prev <= 1'b1;
			valid <= 1'b0;
		end else begin
			rx_prev <= rx;
			valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				mitm_pkg::RX_IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx)	// falling edge of start bit
						state <= mitm_pkg::RX_START;
				end
				mitm_pkg::RX_START: begin
					if (clk_cnt == HALF_BIT) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// false start if the line is high again
						state <= rx ? mitm_pkg::RX_IDLE : mitm_pkg::RX_DATA;
					end
				end
				mitm_pkg::RX_DATA: begin
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_BIT)
							state <= mitm_pkg::RX_STOP;
					end
				end
				mitm_pkg::RX_STOP: begin
					if (clk_cnt == FULL_BIT) begin
						valid <= rx;	// low stop bit drops the frame
						state <= mitm_pkg::RX_IDLE;
					end
				end
				default: state <= mitm_pkg::RX_IDLE;
			endcase
		end
	end

	// lsb first, sampled at mid-bit
	always_ff @(posedge sys_clk) begin
		if (state == mitm_pkg::RX_DATA && clk_cnt == FULL_BIT)
			data <= {rx, data[`MITM_DATA_BITS-1:1]};
	end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
// uart transmitter, start strobe in and busy level out
`default_nettype none
`timescale 1ns/1ps

`include "mitm_params.svh"

module uart_tx (
	input wire sys_clk,
	input wire rst_n,
	input wire start,
	input wire [`MITM_DATA_BITS-1:0] data,
	output logic tx,
	output logic busy
);

	localparam int CNT_W = $clog2(`MITM_CLKS_PER_BIT);
	localparam int IDX_W = $clog2(`MITM_DATA_BITS);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`MITM_CLKS_PER_BIT - 1);
	localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`MITM_DATA_BITS - 1);

	mitm_pkg::uart_tx_state_e state;
	logic [CNT_W-1:0] clk_cnt;
	logic [IDX_W-1:0] bit_idx;
	logic [`MITM_DATA_BITS-1:0] shreg;
	logic bit_end;

	assign bit_end = (clk_cnt == FULL_BIT);
	assign busy = (state != mitm_pkg::TX_IDLE);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state <= mitm_pkg::TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;	// idle line high
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				mitm_pkg::TX_IDLE: begin
					clk_cnt <= '0;
					if (start) begin
						tx <= 1'b0;	// start bit
						state <= mitm_pkg::TX_START;
					end
				end
				mitm_pkg::TX_START: begin
					if (bit_end) begin
						tx <= shreg[0];
						bit_idx <= '0;
						state <= mitm_pkg::TX_DATA;
					end
				end
				mitm_pkg::TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_BIT) begin
							tx <= 1'b1;	// stop bit
							state <= mitm_pkg::TX_STOP;
						end else begin
							tx <= shreg[0];
						end
					end
				end
				mitm_pkg::TX_STOP: begin
					if (bit_end)
						state <= mitm_pkg::TX_IDLE;
				end
				default: state <= mitm_pkg::TX_IDLE;
			endcase
		end
	end

	// byte latched on start, shifted out lsb first
	always_ff @(posedge sys_clk) begin
		if (state == mitm_pkg::TX_IDLE && start)
			shreg <= data;
		else if (bit_end && state != mitm_pkg::TX_IDLE && state != mitm_pkg::TX_STOP)
			shreg <= {1'b0, shreg[`MITM_DATA_BITS-1:1]};
	end

endmodule

`default_nettype wire

//--- verilog/bus_interface.sv
// uart bus interface, one receiver and one transmitter per side
`default_nettype none
`timescale 1ns/1ps

`include "mitm_params.svh"

module bus_interface (
	input wire sys_clk,
	input wire rst_n,
	input wire if0_rx,
	input wire if1_rx,
	output logic if0_tx,
	output logic if1_tx,
	output logic if0_rx_valid,
	output logic if1_rx_valid,
	output logic [`MITM_DATA_BITS-1:0] if0_rx_data,
	output logic [`MITM_DATA_BITS-1:0] if1_rx_data,
	input wire if0_tx_start,
	input wire if1_tx_start,
	input wire [`MITM_DATA_BITS-1:0] if0_tx_data,
	input wire [`MITM_DATA_BITS-1:0] if1_tx_data,
	output logic if0_tx_busy,
	output logic if1_tx_busy
);

	// interface 0 side
	uart_rx rx0 (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.rx(if0_rx),
		.valid(if0_rx_valid),
		.data(if0_rx_data)
	);

	uart_tx tx0 (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.start(if0_tx_start),
		.data(if0_tx_data),
		.tx(if0_tx),
		.busy(if0_tx_busy)
	);

	// interface 1 side
	uart_rx rx1 (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.rx(if1_rx),
		.valid(if1_rx_valid),
		.data(if1_rx_data)
	);

	uart_tx tx1 (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.start(if1_tx_start),
		.data(if1_tx_data),
		.tx(if1_tx),
		.busy(if1_tx_busy)
	);

endmodule

`default_nettype wire

//--- verilog/mitm_logic.sv
// mitm logic, mode dependent byte manipulation with per direction hold registers
`default_nettype none
`timescale 1ns/1ps

`include "mitm_params.svh"

module mitm_logic (
	input wire sys_clk,
	input wire rst_n,
	input wire mitm_pkg::mitm_mode_e mode,
	input wire if0_rx_valid,
	input wire if1_rx_valid,
	input wire [`MITM_DATA_BITS-1:0] if0_rx_data,
	input wire [`MITM_DATA_BITS-1:0] if1_rx_data,
	input wire if0_tx_busy,
	input wire if1_tx_busy,
	output logic if0_tx_start,
	output logic if1_tx_start,
	output logic [`MITM_DATA_BITS-1:0] if0_tx_data,
	output logic [`MITM_DATA_BITS-1:0] if1_tx_data
);

	// direction 0 is if0 to if1, direction 1 is if1 to if0
	logic [1:0] rx_valid;
	logic [`MITM_DATA_BITS-1:0] rx_data [2];
	logic [1:0] tgt_busy;	// busy of the opposite transmitter
	logic [`MITM_DATA_BITS:0] result [2];	// keep flag over byte
	logic [1:0] pending;
	logic [`MITM_DATA_BITS-1:0] hold [2];
	logic [1:0] start;

	// returns {keep, byte}
	function automatic logic [`MITM_DATA_BITS:0] manipulate(
		input mitm_pkg::mitm_mode_e m,
		input logic [`MITM_DATA_BITS-1:0] b
	);
		logic [`MITM_DATA_BITS:0] r;
		case (m)
			mitm_pkg::MODE_BLOCK: r = {1'b0, b};
			mitm_pkg::MODE_INVERT: r = {1'b1, ~b};
			mitm_pkg::MODE_SUBST: r = {1'b1, (b == `MITM_MATCH_BYTE) ? `MITM_SUBST_BYTE : b};
			default: r = {1'b1, b};	// forward
		endcase
		return r;
	endfunction

	assign rx_valid = {if1_rx_valid, if0_rx_valid};
	assign rx_data[0] = if0_rx_data;
	assign rx_data[1] = if1_rx_data;
	assign tgt_busy = {if0_tx_busy, if1_tx_busy};

	always_comb begin
		for (int d = 0; d < 2; d++)
			result[d] = manipulate(mode, rx_data[d]);
	end

	// start as soon as the target transmitter is free
	assign start = pending & ~tgt_busy;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			for (int d = 0; d < 2; d++) begin
				if (rx_valid[d] && result[d][`MITM_DATA_BITS])
					pending[d] <= 1'b1;	// new byte overwrites a waiting one
				else if (start[d])
					pending[d] <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		for (int d = 0; d < 2; d++) begin
			if (rx_valid[d] && result[d][`MITM_DATA_BITS])
				hold[d] <= result[d][`MITM_DATA_BITS-1:0];
		end
	end

	assign if1_tx_start = start[0];
	assign if1_tx_data = hold[0];
	assign if0_tx_start = start[1];
	assign if0_tx_data = hold[1];

endmodule

`default_nettype wire

//--- verilog/mitm_top.sv
// uart mitm top level, joins synchronizer, i/o handler, bus interface and mitm logic
`default_nettype none
`timescale 1ns/1ps

`include "mitm_params.svh"

module mitm_top (
	input wire sys_clk,
	input wire rst_n,
	input wire mode_btn,	// active high, bouncing
	input wire if0_rx,
	input wire if1_rx,
	output logic if0_tx,
	output logic if1_tx,
	output logic [`MITM_MODE_WIDTH-1:0] mode_leds,
	output logic comm_active_led
);

	logic sync_mode_btn;
	logic sync_if0_rx;
	logic sync_if1_rx;
	mitm_pkg::mitm_mode_e mode;
	logic comm_active;

	logic if0_rx_valid;
	logic if1_rx_valid;
	logic [`MITM_DATA_BITS-1:0] if0_rx_data;
	logic [`MITM_DATA_BITS-1:0] if1_rx_data;
	logic if0_tx_start;
	logic if1_tx_start;
	logic [`MITM_DATA_BITS-1:0] if0_tx_data;
	logic [`MITM_DATA_BITS-1:0] if1_tx_data;
	logic if0_tx_busy;
	logic if1_tx_busy;

	// any low line means a frame in progress
	assign comm_active = ~sync_if0_rx | ~sync_if1_rx | ~if0_tx | ~if1_tx;

	line_sync #(
		.WIDTH(3)
	) sync (
		.sys_clk(sys_clk),
		.in_line({mode_btn, if0_rx, if1_rx}),
		.out_line({sync_mode_btn, sync_if0_rx, sync_if1_rx})
	);

	io_handler io (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.mode_btn(sync_mode_btn),
		.comm_active(comm_active),
		.mode(mode),
		.mode_leds(mode_leds),
		.comm_active_led(comm_active_led)
	);

	bus_interface bus (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.if0_rx(sync_if0_rx), .if1_rx(sync_if1_rx),
		.if0_tx(if0_tx), .if1_tx(if1_tx),
		.if0_rx_valid(if0_rx_valid), .if1_rx_valid(if1_rx_valid),
		.if0_rx_data(if0_rx_data), .if1_rx_data(if1_rx_data),
		.if0_tx_start(if0_tx_start), .if1_tx_start(if1_tx_start),
		.if0_tx_data(if0_tx_data), .if1_tx_data(if1_tx_data),
		.if0_tx_busy(if0_tx_busy), .if1_tx_busy(if1_tx_busy)
	);

	mitm_logic logic_core (
		.sys_clk(sys_clk), .rst_n(rst_n), .mode(mode),
		.if0_rx_valid(if0_rx_valid), .if1_rx_valid(if1_rx_valid),
		.if0_rx_data(if0_rx_data), .if1_rx_data(if1_rx_data),
		.if0_tx_busy(if0_tx_busy), .if1_tx_busy(if1_tx_busy),
		.if0_tx_start(if0_tx_start), .if1_tx_start(if1_tx_start),
		.if0_tx_data(if0_tx_data), .if1_tx_data(if1_tx_data)
	);

endmodule

`default_nettype wire

//--- testbench/tb_uart_line.sv
// testbench uart line model, sends frames into a dut rx pin and decodes a dut tx pin
`default_nettype none
`timescale 1ns/1ps

`include "mitm_params.svh"

module tb_uart_line (
	input wire sys_clk,
	output logic line_out,	// into dut rx
	input wire line_in	// from the opposite dut tx
);

	initial line_out = 1'b1;

	task automatic send_byte(input logic [`MITM_DATA_BITS-1:0] b);
		logic [`MITM_DATA_BITS+1:0] frame;
		frame = {1'b1, b, 1'b0};	// stop, data, start
		for (int i = 0; i < `MITM_DATA_BITS + 2; i++) begin
			@(posedge sys_clk);
			line_out <= frame[i];
			repeat (`MITM_CLKS_PER_BIT - 1) @(posedge sys_clk);
		end
	endtask

	// status 0 means timeout, 1 a good frame, 2 a low stop bit
	task automatic recv_byte(input int timeout, output logic [`MITM_DATA_BITS-1:0] b,
		output int status);
		int waited;
		waited = 0;
		b = '0;
		status = 0;
		while (line_in && waited < timeout) begin
			@(posedge sys_clk);
			waited++;
		end
		if (!line_in) begin
			repeat (`MITM_CLKS_PER_BIT / 2) @(posedge sys_clk);	// middle of start bit
			for (int i = 0; i < `MITM_DATA_BITS; i++) begin
				repeat (`MITM_CLKS_PER_BIT) @(posedge sys_clk);
				b[i] = line_in;	// lsb first
			end
			repeat (`MITM_CLKS_PER_BIT) @(posedge sys_clk);
			status = line_in ? 1 : 2;
		end
	endtask

endmodule

`default_nettype wire

//--- testbench/tb_mitm_top.sv
// table driven testbench for the uart mitm top level over all four modes
`default_nettype none
`timescale 1ns/1ps

`include "mitm_params.svh"

module tb_mitm_top;

	localparam int N = 10;
	localparam int FRAME_WAIT = 20 * `MITM_CLKS_PER_BIT;	// two frames

	logic sys_clk = 1'b0;
	logic rst_n;
	logic mode_btn;
	wire if0_rx;
	wire if1_rx;
	wire if0_tx;
	wire if1_tx;
	wire [`MITM_MODE_WIDTH-1:0] mode_leds;
	wire comm_active_led;

	// stimulus table with one array per column
	string name [N];
	mitm_pkg::mitm_mode_e mode_req [N];
	logic dir [N];	// 0 sends on if0 and 1 on if1
	logic [7:0] in_byte [N];
	logic expect_frame [N];
	logic [7:0] out_byte [N];
	int n_entries = 0;

	int pass_cnt = 0;
	int fail_cnt = 0;
	logic [31:0] rnd = 32'hfd5a_dd5e;
	mitm_pkg::mitm_mode_e exp_mode = mitm_pkg::MODE_FORWARD;

	always #4 sys_clk = ~sys_clk;

	mitm_top dut (
		.sys_clk(sys_clk), .rst_n(rst_n), .mode_btn(mode_btn),
		.if0_rx(if0_rx), .if1_rx(if1_rx), .if0_tx(if0_tx), .if1_tx(if1_tx),
		.mode_leds(mode_leds), .comm_active_led(comm_active_led)
	);

	tb_uart_line line0 (.sys_clk(sys_clk), .line_out(if0_rx), .line_in(if1_tx));
	tb_uart_line line1 (.sys_clk(sys_clk), .line_out(if1_rx), .line_in(if0_tx));

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic tally(input bit ok, input string tname, input string exp_s, input string act_s);
		if (ok) begin
			pass_cnt++;
			$display("ok     %s %s", tname, act_s);
		end else begin
			fail_cnt++;
			$display("FAILED %s expected %s actual %s", tname, exp_s, act_s);
		end
	endtask

	task automatic check_byte(input string tname, input logic [7:0] exp_v, input logic [7:0] act);
		tally(act === exp_v, tname, $sformatf("%02h", exp_v), $sformatf("%02h", act));
	endtask

	task automatic check_mode(input string tname, input mitm_pkg::mitm_mode_e exp_v,
		input mitm_pkg::mitm_mode_e act);
		tally(act === exp_v, tname, exp_v.name(), act.name());
	endtask

	task automatic check_bit(input string tname, input logic exp_v, input logic act);
		tally(act === exp_v, tname, $sformatf("%b", exp_v), $sformatf("%b", act));
	endtask

	// hold the button and release it long enough for the low level to settle
	task automatic press_button(input int high_cycles);
		@(posedge sys_clk);
		mode_btn <= 1'b1;
		repeat (high_cycles) @(posedge sys_clk);
		mode_btn <= 1'b0;
		repeat (`MITM_DEBOUNCE_CYCLES + 8) @(posedge sys_clk);
	endtask

	task automatic add_entry(input string tname, input mitm_pkg::mitm_mode_e m, input logic d,
		input logic [7:0] b, input logic exp_frame, input logic [7:0] exp_b);
		name[n_entries] = tname;
		mode_req[n_entries] = m;
		dir[n_entries] = d;
		in_byte[n_entries] = b;
		expect_frame[n_entries] = exp_frame;
		out_byte[n_entries] = exp_b;
		n_entries++;
	endtask

	initial begin
		logic [7:0] got;
		int status;
		logic led_before;
		rst_n = 1'b0;
		mode_btn = 1'b0;
		add_entry("fwd_if0", mitm_pkg::MODE_FORWARD, 1'b0, 8'ha5, 1'b1, 8'ha5);
		rnd = xorshift32(rnd);
		add_entry("fwd_if1_rnd", mitm_pkg::MODE_FORWARD, 1'b1, rnd[7:0], 1'b1, rnd[7:0]);
		add_entry("blk_if0", mitm_pkg::MODE_BLOCK, 1'b0, 8'h3c, 1'b0, 8'h00);
		add_entry("blk_if1", mitm_pkg::MODE_BLOCK, 1'b1, 8'h41, 1'b0, 8'h00);
		add_entry("inv_if0", mitm_pkg::MODE_INVERT, 1'b0, 8'h0f, 1'b1, 8'hf0);
		rnd = xorshift32(rnd);
		add_entry("inv_if1_rnd", mitm_pkg::MODE_INVERT, 1'b1, rnd[7:0], 1'b1, ~rnd[7:0]);
		add_entry("sub_match_if0", mitm_pkg::MODE_SUBST, 1'b0, 8'h41, 1'b1, 8'h5a);
		add_entry("sub_match_if1", mitm_pkg::MODE_SUBST, 1'b1, 8'h41, 1'b1, 8'h5a);
		add_entry("sub_other_if1", mitm_pkg::MODE_SUBST, 1'b1, 8'h42, 1'b1, 8'h42);
		rnd = xorshift32(rnd);
		add_entry("fwd_wrap_if0", mitm_pkg::MODE_FORWARD, 1'b0, rnd[7:0], 1'b1, rnd[7:0]);

		repeat (5) @(posedge sys_clk);
		rst_n <= 1'b1;
		@(posedge sys_clk);
		check_bit("reset_if0_tx", 1'b1, if0_tx);
		check_bit("reset_if1_tx", 1'b1, if1_tx);
		check_mode("reset_mode", mitm_pkg::MODE_FORWARD, mitm_pkg::mitm_mode_e'(mode_leds));
		check_bit("reset_led", 1'b0, comm_active_led);
		press_button(`MITM_DEBOUNCE_CYCLES / 2);	// too short to count
		check_mode("short_press", mitm_pkg::MODE_FORWARD, mitm_pkg::mitm_mode_e'(mode_leds));

		for (int t = 0; t < n_entries; t++) begin
			// step at most one full cycle of modes
			for (int p = 0; p < 4 && exp_mode != mode_req[t]; p++) begin
				press_button(`MITM_DEBOUNCE_CYCLES + 8);
				exp_mode = mitm_pkg::mitm_mode_e'((exp_mode + 1) % 4);
				check_mode({name[t], "_mode"}, exp_mode, mitm_pkg::mitm_mode_e'(mode_leds));
			end
			led_before = comm_active_led;
			fork
				begin
					if (dir[t])
						line1.send_byte(in_byte[t]);
					else
						line0.send_byte(in_byte[t]);
				end
				begin
					if (dir[t])
						line1.recv_byte(FRAME_WAIT, got, status);
					else
						line0.recv_byte(FRAME_WAIT, got, status);
				end
				begin
					repeat (3 * `MITM_CLKS_PER_BIT) @(posedge sys_clk);	// mid frame
					if (!led_before)	// led dark before the frame
						check_bit({name[t], "_led"}, 1'b1, comm_active_led);
				end
			join
			if (status == 0 && expect_frame[t]) begin
				fail_cnt++;
				$display("%s: no frame arrived on the opposite tx line in time", name[t]);
			end else if (status == 2) begin
				fail_cnt++;
				$display("%s: frame on the opposite tx line had a low stop bit", name[t]);
			end else if (expect_frame[t]) begin
				check_byte(name[t], out_byte[t], got);
			end else begin
				tally(status == 0, name[t], "no frame", $sformatf("frame %02h", got));
			end
		end

		// idle lines let the led time out
		repeat (`MITM_LED_HOLD_CYCLES + 32) @(posedge sys_clk);
		check_bit("led_idle", 1'b0, comm_active_led);

		$display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
verilog/mitm_pkg.sv
verilog/line_sync.sv
verilog/io_handler.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/bus_interface.sv
verilog/mitm_logic.sv
verilog/mitm_top.sv
testbench/tb_uart_line.sv
testbench/tb_mitm_top.sv
